// ==== include/lc3b_params.svh ====
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// data path width
`define LC3B_WORD_W 16

// architectural registers R0..R7
`define LC3B_NREGS 8

// bits of a register index
`define LC3B_REG_W 3

`endif

// ==== hw/lc3b_types.sv ====
`include "lc3b_params.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

	// IR[15:12] encoding
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	typedef struct packed {
		// decode stage
		logic sr1_sel;
		logic sr2_sel;
		logic sh6_sel;
		logic imm_sel;
		// execute
		logic [1:0] alumux1_sel;
		logic [1:0] alumux2_sel;
		lc3b_aluop alu_ctrl;
		// memory
		logic indirect;
		logic read;
		logic write;
		logic mem_byte_sig;
		logic regfilemux_sel;
		// write-back and pc
		logic load_regfile;
		logic memread_sel;
		logic load_cc;
		logic destmux_sel;
		logic [1:0] pcmux_sel;
		logic pcmux_sel_out_sel;
	} lc3b_ctrl_t;

	typedef struct packed {
		lc3b_word pc;
		lc3b_word sr1_data;
		lc3b_word sr2_data;
		lc3b_word imm;       // imm5 or imm4 for shifts
		lc3b_word offset6;
		lc3b_word offset_pc; // offset9 or offset11 already doubled
		lc3b_word trapvect;
		lc3b_reg dest;
		logic valid;
	} lc3b_operands_t;

endpackage : lc3b_types

// ==== hw/decode.sv ====
`timescale 1ns/1ns

module decode
	import lc3b_types::*;
(
	input lc3b_word instruction,
	output lc3b_ctrl_t ctrl
);

	lc3b_opcode opcode;
	logic ir5;
	logic ir4;
	logic ir11;

	assign opcode = lc3b_opcode'(instruction[15:12]);
	assign ir5 = instruction[5];  // immediate form, arithmetic shift
	assign ir4 = instruction[4];  // shift direction
	assign ir11 = instruction[11]; // jsr vs jsrr

	always_comb begin
		ctrl = '0; // unused fields stay low
		ctrl.alu_ctrl = alu_pass;

		case (opcode)
			op_add, op_and: begin
				ctrl.alumux2_sel = ir5 ? 2'b11 : 2'b00;
				ctrl.alu_ctrl = (opcode == op_add) ? alu_add : alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_not: begin
				ctrl.alu_ctrl = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_ldr: begin
				ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01; // base + offset6
				ctrl.alu_ctrl = alu_add;
				ctrl.read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end

			op_ldb: begin
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = alu_add;
				ctrl.read = 1'b1;
				ctrl.mem_byte_sig = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end

			op_ldi: begin
				ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = alu_add;
				ctrl.indirect = 1'b1; // second read through the loaded pointer
				ctrl.read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end

			op_str: begin
				ctrl.sr2_sel = 1'b1; // store data from IR[11:9]
				ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = alu_add;
				ctrl.write = 1'b1;
			end

			op_stb: begin
				ctrl.sr2_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = alu_add;
				ctrl.write = 1'b1;
				ctrl.mem_byte_sig = 1'b1;
			end

			op_sti: begin
				ctrl.sr2_sel = 1'b1;
				ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = alu_add;
				ctrl.indirect = 1'b1;
				ctrl.write = 1'b1;
			end

			op_br: begin
				ctrl.alumux1_sel = 2'b01; // pc + offset9
				ctrl.alumux2_sel = 2'b10;
				ctrl.alu_ctrl = alu_add;
				ctrl.pcmux_sel_out_sel = 1'b1; // condition decided later
			end

			op_jmp: begin
				ctrl.regfilemux_sel = 1'b1;
				ctrl.pcmux_sel = 2'b01;
			end

			op_jsr: begin
				if (ir11) begin
					ctrl.alumux1_sel = 2'b10; // pc + offset11
					ctrl.alumux2_sel = 2'b10;
					ctrl.alu_ctrl = alu_add;
				end
				ctrl.destmux_sel = 1'b1; // link into R7
				ctrl.regfilemux_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.pcmux_sel = 2'b01;
			end

			op_lea: begin
				ctrl.alumux1_sel = 2'b01;
				ctrl.alumux2_sel = 2'b10;
				ctrl.alu_ctrl = alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_shf: begin
				ctrl.imm_sel = 1'b1; // amount is imm4
				ctrl.alumux2_sel = 2'b11;
				if (!ir4)
					ctrl.alu_ctrl = alu_sll;
				else if (!ir5)
					ctrl.alu_ctrl = alu_srl;
				else
					ctrl.alu_ctrl = alu_sra;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_trap: begin
				ctrl.alumux1_sel = 2'b11; // vector table address
				ctrl.destmux_sel = 1'b1;
				ctrl.read = 1'b1;
				ctrl.regfilemux_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.pcmux_sel = 2'b11;
			end

			default: begin
				// rti is not supported in the pipeline, treat as a bubble
				ctrl = '0;
				ctrl.alu_ctrl = alu_pass;
			end
		endcase
	end

endmodule : decode

// ==== hw/regfile.sv ====
`timescale 1ns/1ns
`include "lc3b_params.svh"

module regfile
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input logic wb_en,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	input lc3b_reg sr1_idx,
	input lc3b_reg sr2_idx,
	output lc3b_word sr1_data,
	output lc3b_word sr2_data
);

	lc3b_word regs [`LC3B_NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_dest] <= wb_data; // R0 is writable
		end
	end

	// write-first bypass lets a reader see the same-cycle write-back
	assign sr1_data = (wb_en && wb_dest == sr1_idx) ? wb_data : regs[sr1_idx];
	assign sr2_data = (wb_en && wb_dest == sr2_idx) ? wb_data : regs[sr2_idx];

endmodule : regfile

// ==== hw/operand_gen.sv ====
`timescale 1ns/1ns
`include "lc3b_params.svh"

module operand_gen
	import lc3b_types::*;
(
	input lc3b_word instruction,
	input lc3b_word pc,
	input lc3b_ctrl_t ctrl,
	output lc3b_reg sr1_idx,
	output lc3b_reg sr2_idx,
	output lc3b_operands_t ops
);

	lc3b_word imm5_sext;
	lc3b_word imm4_zext;
	lc3b_word off6_sext;
	lc3b_word off9_sext;
	lc3b_word off11_sext;
	logic jsr_long;

	assign imm5_sext = {{(`LC3B_WORD_W-5){instruction[4]}}, instruction[4:0]};
	assign imm4_zext = {{(`LC3B_WORD_W-4){1'b0}}, instruction[3:0]};
	assign off6_sext = {{(`LC3B_WORD_W-6){instruction[5]}}, instruction[5:0]};
	assign off9_sext = {{(`LC3B_WORD_W-9){instruction[8]}}, instruction[8:0]};
	assign off11_sext = {{(`LC3B_WORD_W-11){instruction[10]}}, instruction[10:0]};

	// only jsr with IR[11] set routes pc into alumux1 input 2
	assign jsr_long = (ctrl.alumux1_sel == 2'b10);

	assign sr1_idx = ctrl.sr1_sel ? instruction[11:9] : instruction[8:6];
	assign sr2_idx = ctrl.sr2_sel ? instruction[11:9] : instruction[2:0];

	always_comb begin
		ops = '0;
		ops.pc = pc;
		ops.imm = ctrl.imm_sel ? imm4_zext : imm5_sext;
		ops.offset6 = ctrl.sh6_sel ? (off6_sext << 1) : off6_sext; // word vs byte access
		ops.offset_pc = jsr_long ? (off11_sext << 1) : (off9_sext << 1);
		ops.trapvect = {{(`LC3B_WORD_W-9){1'b0}}, instruction[7:0], 1'b0};
		ops.dest = ctrl.destmux_sel ? lc3b_reg'(`LC3B_NREGS - 1) : instruction[11:9];
	end

endmodule : operand_gen

// ==== hw/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0; // wins over a held stall
		end else if (load) begin
			q <= d;
		end
	end

endmodule : stage_reg

// ==== hw/id_stage.sv ====
`timescale 1ns/1ns

module id_stage
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word instruction,
	input logic instr_valid,
	input lc3b_word pc,
	input logic stall,
	input logic flush,
	input logic wb_en,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	output lc3b_ctrl_t ex_ctrl,
	output lc3b_operands_t ex_ops
);

	lc3b_ctrl_t ctrl;
	lc3b_ctrl_t ctrl_d;
	lc3b_operands_t ops_gen;
	lc3b_operands_t ops_d;
	lc3b_reg sr1_idx;
	lc3b_reg sr2_idx;
	lc3b_word sr1_data;
	lc3b_word sr2_data;

	decode u_decode (
		.instruction(instruction),
		.ctrl(ctrl)
	);

	operand_gen u_operand_gen (
		.instruction(instruction),
		.pc(pc),
		.ctrl(ctrl),
		.sr1_idx(sr1_idx),
		.sr2_idx(sr2_idx),
		.ops(ops_gen)
	);

	regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.sr1_idx(sr1_idx),
		.sr2_idx(sr2_idx),
		.sr1_data(sr1_data),
		.sr2_data(sr2_data)
	);

	assign ctrl_d = instr_valid ? ctrl : '0; // bubble does nothing downstream

	always_comb begin
		ops_d = ops_gen;
		ops_d.sr1_data = sr1_data;
		ops_d.sr2_data = sr2_data;
		ops_d.valid = instr_valid;
	end

	stage_reg #(.payload_t(lc3b_ctrl_t)) u_ctrl_reg (
		.clk(clk),
		.rst_n(rst_n),
		.load(!stall),
		.flush(flush),
		.d(ctrl_d),
		.q(ex_ctrl)
	);

	stage_reg #(.payload_t(lc3b_operands_t)) u_ops_reg (
		.clk(clk),
		.rst_n(rst_n),
		.load(!stall),
		.flush(flush),
		.d(ops_d),
		.q(ex_ops)
	);

endmodule : id_stage

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ns
`include "lc3b_params.svh"

module tb_id_stage
	import lc3b_types::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int N_OPC = 16 * 8; // every opcode with IR[11], IR[5], IR[4] varied
	localparam int N_REGWR = `LC3B_NREGS;
	localparam int N_REGRD = 64;
	localparam int N_IMM = 64;
	localparam int N_STROBE = 8;
	localparam int N_MIX = 2000;
	localparam int N_DRAIN = 3;
	localparam int STIM_CYCLES = N_OPC + N_REGWR + N_REGRD + N_IMM + N_STROBE + N_MIX + N_DRAIN;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + RESET_CYCLES;

	logic clk;
	logic rst_n;
	lc3b_word instruction;
	logic instr_valid;
	lc3b_word pc;
	logic stall;
	logic flush;
	logic wb_en;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_ctrl_t ex_ctrl;
	lc3b_operands_t ex_ops;

	logic [31:0] lfsr;
	lc3b_word shadow [`LC3B_NREGS]; // mirrors the write-back writes
	lc3b_ctrl_t exp_ctrl;
	lc3b_operands_t exp_ops;
	logic model_ready;
	int cycle_count;

	id_stage u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instruction(instruction),
		.instr_valid(instr_valid),
		.pc(pc),
		.stall(stall),
		.flush(flush),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.ex_ctrl(ex_ctrl),
		.ex_ops(ex_ops)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // galois step
		end
		return r;
	endfunction

	function automatic lc3b_word rand_word();
		return lc3b_word'(rand_bits(16));
	endfunction

	function automatic lc3b_ctrl_t ref_ctrl(input lc3b_word ir);
		lc3b_ctrl_t c;
		lc3b_opcode op;
		logic is_ld;
		logic is_st;
		logic jsr_long;
		op = lc3b_opcode'(ir[15:12]);
		is_ld = op inside {op_ldr, op_ldb, op_ldi};
		is_st = op inside {op_str, op_stb, op_sti};
		jsr_long = (op == op_jsr) && ir[11];
		c = '0;
		c.sr2_sel = is_st;
		c.sh6_sel = op inside {op_ldr, op_ldi, op_str, op_sti}; // word accesses
		c.imm_sel = (op == op_shf);
		if (op == op_br || op == op_lea)
			c.alumux1_sel = 2'b01;
		else if (jsr_long)
			c.alumux1_sel = 2'b10;
		else if (op == op_trap)
			c.alumux1_sel = 2'b11;
		if (is_ld || is_st)
			c.alumux2_sel = 2'b01;
		else if (op == op_br || op == op_lea || jsr_long)
			c.alumux2_sel = 2'b10;
		else if (op == op_shf || ((op == op_add || op == op_and) && ir[5]))
			c.alumux2_sel = 2'b11;
		c.alu_ctrl = alu_pass;
		if (op == op_add || is_ld || is_st || op == op_br || op == op_lea || jsr_long)
			c.alu_ctrl = alu_add;
		else if (op == op_and)
			c.alu_ctrl = alu_and;
		else if (op == op_not)
			c.alu_ctrl = alu_not;
		else if (op == op_shf)
			c.alu_ctrl = ir[4] ? (ir[5] ? alu_sra : alu_srl) : alu_sll;
		c.indirect = op inside {op_ldi, op_sti};
		c.read = is_ld || (op == op_trap);
		c.write = is_st;
		c.mem_byte_sig = op inside {op_ldb, op_stb};
		c.regfilemux_sel = op inside {op_jmp, op_jsr, op_trap};
		c.load_cc = is_ld || (op inside {op_add, op_and, op_not, op_lea, op_shf});
		c.load_regfile = c.load_cc || (op inside {op_jsr, op_trap});
		c.memread_sel = is_ld;
		c.destmux_sel = op inside {op_jsr, op_trap}; // link register R7
		if (op == op_jmp || op == op_jsr)
			c.pcmux_sel = 2'b01;
		else if (op == op_trap)
			c.pcmux_sel = 2'b11;
		c.pcmux_sel_out_sel = (op == op_br);
		return c;
	endfunction

	function automatic lc3b_word shadow_read(input lc3b_reg idx, input logic we,
		input lc3b_reg wd, input lc3b_word wdata);
		if (we && wd == idx)
			return wdata; // same-cycle write-back wins
		return shadow[idx];
	endfunction

	function automatic lc3b_operands_t ref_ops(input lc3b_word ir, input lc3b_word pc_in,
		input logic valid_in, input logic we, input lc3b_reg wd, input lc3b_word wdata);
		lc3b_operands_t o;
		lc3b_ctrl_t c;
		lc3b_opcode op;
		c = ref_ctrl(ir);
		op = lc3b_opcode'(ir[15:12]);
		o.pc = pc_in;
		o.sr1_data = shadow_read(c.sr1_sel ? ir[11:9] : ir[8:6], we, wd, wdata);
		o.sr2_data = shadow_read(c.sr2_sel ? ir[11:9] : ir[2:0], we, wd, wdata);
		if (op == op_shf)
			o.imm = {12'h000, ir[3:0]};
		else
			o.imm = 16'($signed(ir[4:0]));
		o.offset6 = 16'($signed(ir[5:0]));
		if (c.sh6_sel)
			o.offset6 = o.offset6 << 1;
		if (op == op_jsr && ir[11])
			o.offset_pc = 16'($signed(ir[10:0])) << 1;
		else
			o.offset_pc = 16'($signed(ir[8:0])) << 1;
		o.trapvect = {7'd0, ir[7:0], 1'b0};
		o.dest = (op == op_jsr || op == op_trap) ? 3'd7 : ir[11:9];
		o.valid = valid_in;
		return o;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] gotv);
		$display("ERROR %s expected %h got %h", name, expv, gotv);
		stop_with_failure();
	endtask

	task automatic check_ctrl(input lc3b_ctrl_t expv, input lc3b_ctrl_t gotv);
		if (gotv !== expv)
			report_mismatch("ex_ctrl", expv, gotv);
	endtask

	task automatic check_ops(input lc3b_operands_t expv, input lc3b_operands_t gotv);
		if (gotv.valid !== expv.valid)
			report_mismatch("ex_ops.valid", expv.valid, gotv.valid);
		else if (gotv.dest !== expv.dest)
			report_mismatch("ex_ops.dest", expv.dest, gotv.dest);
		else if (gotv.pc !== expv.pc)
			report_mismatch("ex_ops.pc", expv.pc, gotv.pc);
		else if (gotv.sr1_data !== expv.sr1_data)
			report_mismatch("ex_ops.sr1_data", expv.sr1_data, gotv.sr1_data);
		else if (gotv.sr2_data !== expv.sr2_data)
			report_mismatch("ex_ops.sr2_data", expv.sr2_data, gotv.sr2_data);
		else if (gotv.imm !== expv.imm)
			report_mismatch("ex_ops.imm", expv.imm, gotv.imm);
		else if (gotv.offset6 !== expv.offset6)
			report_mismatch("ex_ops.offset6", expv.offset6, gotv.offset6);
		else if (gotv.offset_pc !== expv.offset_pc)
			report_mismatch("ex_ops.offset_pc", expv.offset_pc, gotv.offset_pc);
		else if (gotv.trapvect !== expv.trapvect)
			report_mismatch("ex_ops.trapvect", expv.trapvect, gotv.trapvect);
	endtask

	// boundary model sampling the same inputs as the DUT
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_ctrl = '0;
			exp_ops = '0;
			for (int i = 0; i < `LC3B_NREGS; i++)
				shadow[i] = '0;
		end else begin
			if (flush) begin
				exp_ctrl = '0;
				exp_ops = '0;
			end else if (!stall) begin
				exp_ctrl = instr_valid ? ref_ctrl(instruction) : '0;
				exp_ops = ref_ops(instruction, pc, instr_valid, wb_en, wb_dest, wb_data);
			end
			if (wb_en)
				shadow[wb_dest] = wb_data;
		end
		model_ready = 1'b1;
	end

	always @(negedge clk) begin
		if (model_ready) begin
			check_ctrl(exp_ctrl, ex_ctrl);
			check_ops(exp_ops, ex_ops);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("run did not complete within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	task automatic drive_cycle(input lc3b_word ir, input logic valid_in, input logic stall_in,
		input logic flush_in, input logic we, input lc3b_reg wd, input lc3b_word wdata);
		instruction = ir;
		instr_valid = valid_in;
		pc = rand_word();
		stall = stall_in;
		flush = flush_in;
		wb_en = we;
		wb_dest = wd;
		wb_data = wdata;
		@(negedge clk);
	endtask

	initial begin
		lc3b_word ir;
		lc3b_reg wd;
		clk = 1'b0;
		rst_n = 1'b0;
		lfsr = 32'h94fc_dd76;
		model_ready = 1'b0;
		cycle_count = 0;
		instruction = '0;
		instr_valid = 1'b0;
		pc = '0;
		stall = 1'b0;
		flush = 1'b0;
		wb_en = 1'b0;
		wb_dest = '0;
		wb_data = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		if (ex_ops.valid !== 1'b0 || ex_ctrl.read !== 1'b0 || ex_ctrl.write !== 1'b0
			|| ex_ctrl.load_regfile !== 1'b0 || ex_ctrl.load_cc !== 1'b0) begin
			$display("boundary registers are not inactive after reset");
			stop_with_failure();
		end

		for (int o = 0; o < 16; o++) begin
			for (int k = 0; k < 8; k++) begin
				ir = rand_word();
				ir[15:12] = o[3:0];
				ir[11] = k[2];
				ir[5] = k[1];
				ir[4] = k[0];
				drive_cycle(ir, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
			end
		end

		for (int r = 0; r < N_REGWR; r++)
			drive_cycle(16'h0000, 1'b0, 1'b0, 1'b0, 1'b1, r[2:0], rand_word());
		for (int n = 0; n < N_REGRD; n++) begin
			ir = rand_word();
			ir[15:12] = (n % 3 == 0) ? op_add : ((n % 3 == 1) ? op_str : op_jsr);
			wd = (n % 4 == 0) ? ir[8:6] : lc3b_reg'(rand_bits(3)); // bypass on sr1
			drive_cycle(ir, 1'b1, 1'b0, 1'b0, (n % 4 == 0) || rand_bits(1) == 1, wd,
				rand_word());
		end

		for (int n = 0; n < N_IMM; n++) begin
			ir = rand_word();
			ir[15:12] = n[3:0];
			ir[11] = n[4]; // both jsr forms
			drive_cycle(ir, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
		end

		ir = rand_word();
		ir[15:12] = op_ldr;
		drive_cycle(ir, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
		ir[15:12] = op_add;
		for (int n = 0; n < 3; n++)
			drive_cycle(ir, 1'b1, 1'b1, 1'b0, n == 1, ir[8:6], rand_word());
		drive_cycle(ir, 1'b1, 1'b1, 1'b1, 1'b0, 3'd0, 16'h0000); // flush beats stall
		drive_cycle(ir, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
		drive_cycle(ir, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
		drive_cycle(ir, 1'b1, 1'b0, 1'b1, 1'b0, 3'd0, 16'h0000);

		for (int n = 0; n < N_MIX; n++) begin
			drive_cycle(rand_word(), rand_bits(2) != 0, rand_bits(3) == 0, rand_bits(4) == 0,
				rand_bits(1) == 1, lc3b_reg'(rand_bits(3)), rand_word());
		end

		for (int n = 0; n < N_DRAIN; n++)
			drive_cycle(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 16'h0000);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule : tb_id_stage

// ==== sources.f ====
+incdir+include
hw/lc3b_types.sv
hw/decode.sv
hw/regfile.sv
hw/operand_gen.sv
hw/stage_reg.sv
hw/id_stage.sv
sim/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: lc3b_id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/lc3b_types.sv
      - hw/decode.sv
      - hw/regfile.sv
      - hw/operand_gen.sv
      - hw/stage_reg.sv
      - hw/id_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_id_stage.sv
